/* src.f */
nice_pkg.sv
nice_decode.sv
nice_exec.sv
nice_row_buf.sv
nice_result.sv
nice_core.sv
nice_core_properties.sv
tb_nice_core.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the nice_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_nice_core \
  -o tb_nice_core_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  echo "Verilator build failed, see $BUILD_LOG"
  exit 1
fi

./obj_dir/tb_nice_core_sim > "$SIM_LOG" 2>&1
sim_status=$?
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status, see $SIM_LOG"
  exit 1
fi

if grep -qx "Simulation passed" "$SIM_LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL, see $SIM_LOG"
exit 1

/* tb_nice_core.sv */
// Self-checking testbench for nice_core that runs a stimulus table against a random-latency memory
`timescale 1ns/1ps
`default_nettype none

module tb_nice_core
  import nice_pkg::*;
();

  localparam int          ROW_WORDS      = 3;
  localparam int          MEM_WORDS      = 64;
  localparam int          MAX_LAT        = 3;
  localparam int          NUM_ROWS       = 10;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * 60;
  // Reads of this word come back with err
  localparam logic [5:0]  ERR_WORD       = 6'd50;
  localparam logic [31:0] RAND_SEED      = 32'ha8c801cc;

  // Table row holds instruction, rs1, response stall cycles and expected kind
  typedef struct packed {xlen_t inst; addr_t rs1; logic [3:0] stall; nice_op_e kind;} stim_t;
  // Memory response waiting for its due cycle
  typedef struct packed {int due; icb_rsp_t rsp;} pend_t;

  logic      nice_clk = 1'b0;
  logic      nice_rst_n;
  logic      nice_req_valid;
  logic      nice_req_ready;
  xlen_t     nice_req_inst;
  addr_t     nice_req_rs1;
  logic      nice_rsp_valid;
  logic      nice_rsp_ready;
  nice_rsp_t nice_rsp;
  logic      nice_icb_cmd_valid;
  logic      nice_icb_cmd_ready;
  icb_cmd_t  nice_icb_cmd;
  logic      nice_icb_rsp_valid;
  icb_rsp_t  nice_icb_rsp;
  logic      nice_active;
  logic      nice_mem_holdup;

  // Model memory, shadow memory and shadow row buffer
  xlen_t mem [MEM_WORDS];
  xlen_t mem_exp [MEM_WORDS];
  xlen_t row_exp [ROW_WORDS];
  stim_t stim_table [NUM_ROWS];
  int    timeout_cnt = 0;

  always #2 nice_clk = ~nice_clk;

  nice_core #(.ROW_WORDS(ROW_WORDS)) nice_core_i (
    .nice_clk(nice_clk), .nice_rst_n(nice_rst_n),
    .nice_req_valid(nice_req_valid), .nice_req_ready(nice_req_ready),
    .nice_req_inst(nice_req_inst), .nice_req_rs1(nice_req_rs1),
    .nice_rsp_valid(nice_rsp_valid), .nice_rsp_ready(nice_rsp_ready), .nice_rsp(nice_rsp),
    .nice_icb_cmd_valid(nice_icb_cmd_valid), .nice_icb_cmd_ready(nice_icb_cmd_ready),
    .nice_icb_cmd(nice_icb_cmd), .nice_icb_rsp_valid(nice_icb_rsp_valid),
    .nice_icb_rsp(nice_icb_rsp), .nice_active(nice_active), .nice_mem_holdup(nice_mem_holdup)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////
  // Initial memory contents depend on every address bit
  function automatic xlen_t fill_word(input int i);
    return (32'h9e37_79b9 * xlen_t'(i + 1)) ^ xlen_t'(i << 7);
  endfunction

  // R-type on custom-3 with rd x10, rs1 x1 and rs2 x2
  function automatic xlen_t encode_rtype(input logic [6:0] f7, input logic [2:0] f3);
    return {f7, 5'd2, 5'd1, f3, 5'd10, OPC_CUSTOM3};
  endfunction

  task automatic check_value(input string name, input xlen_t got, input xlen_t want);
    if (got !== want)
    begin
      $display("error %s got 0x%08h expected 0x%08h", name, got, want);
      $display("Simulation failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic compare_memory();
    int i;
    for (i = 0; i < MEM_WORDS; i++)
    begin
      check_value($sformatf("mem[%0d]", i), mem[i], mem_exp[i]);
    end
  endtask

  // One table row does shadow update, request, response check, stall and take
  task automatic run_row(input stim_t s);
    xlen_t      exp_rdat;
    logic       exp_err;
    logic [5:0] base;
    logic [5:0] widx;
    int         i;
    int         k;
    exp_rdat = '0;
    exp_err  = (s.kind == OP_ILLEGAL);
    base     = s.rs1[7:2];
    for (i = 0; i < ROW_WORDS; i++)
    begin
      widx = base + 6'(i);
      if (s.kind == OP_LBUF)
      begin
        row_exp[i] = mem_exp[widx];
      end
      else if (s.kind == OP_SBUF)
      begin
        mem_exp[widx] = row_exp[i];
      end
      else if (s.kind == OP_ROWSUM)
      begin
        row_exp[i] = row_exp[i] + mem_exp[widx];
        exp_rdat   = exp_rdat + mem_exp[widx];
      end
      // Only reads see the error word
      if ((s.kind == OP_LBUF || s.kind == OP_ROWSUM) && widx == ERR_WORD)
      begin
        exp_err = 1'b1;
      end
    end
    nice_req_valid = 1'b1;
    nice_req_inst  = s.inst;
    nice_req_rs1   = s.rs1;
    while (!nice_req_ready)
    begin
      @(negedge nice_clk);
    end
    // Taken at the rising edge in between
    @(negedge nice_clk);
    // Memory operations hold up the core until the last response
    check_value("nice_mem_holdup", 32'(nice_mem_holdup), 32'(s.kind != OP_ILLEGAL));
    nice_req_valid = 1'b0;
    while (!nice_rsp_valid)
    begin
      @(negedge nice_clk);
    end
    check_value("nice_rsp.rdat", nice_rsp.rdat, exp_rdat);
    check_value("nice_rsp.err", 32'(nice_rsp.err), 32'(exp_err));
    // Response must hold while the CPU is not ready
    for (k = 0; k < int'(s.stall); k++)
    begin
      @(negedge nice_clk);
      check_value("nice_rsp_valid", 32'(nice_rsp_valid), 32'd1);
      check_value("nice_rsp.rdat", nice_rsp.rdat, exp_rdat);
      check_value("nice_rsp.err", 32'(nice_rsp.err), 32'(exp_err));
      check_value("nice_active", 32'(nice_active), 32'd1);
      check_value("nice_mem_holdup", 32'(nice_mem_holdup), 32'd0);
    end
    nice_rsp_ready = 1'b1;
    @(negedge nice_clk);
    nice_rsp_ready = 1'b0;
    check_value("nice_rsp_valid", 32'(nice_rsp_valid), 32'd0);
    check_value("nice_req_ready", 32'(nice_req_ready), 32'd1);
    check_value("nice_active", 32'(nice_active), 32'd0);
    if (s.kind == OP_SBUF)
    begin
      compare_memory();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Memory model with in-order responses and random latency
  ////////////////////////////////////////////////////////////
  initial
  begin : memory_model
    pend_t       rsp_q [$];
    pend_t       ent;
    int          mem_cyc;
    int          last_due;
    int          lat;
    int          i;
    int unsigned seed_val;
    logic [5:0]  widx;
    seed_val           = $urandom(RAND_SEED);
    mem_cyc            = 0;
    last_due           = 0;
    nice_icb_cmd_ready = 1'b0;
    nice_icb_rsp_valid = 1'b0;
    nice_icb_rsp       = '0;
    for (i = 0; i < MEM_WORDS; i++)
    begin
      mem[i] = fill_word(i);
    end
    forever
    begin
      @(negedge nice_clk);
      mem_cyc++;
      nice_icb_rsp_valid = 1'b0;
      nice_icb_rsp       = '0;
      if (rsp_q.size() != 0 && rsp_q[0].due <= mem_cyc)
      begin
        ent                = rsp_q.pop_front();
        nice_icb_rsp_valid = 1'b1;
        nice_icb_rsp       = ent.rsp;
      end
      // Ready low about one cycle in four
      nice_icb_cmd_ready = ($urandom_range(3, 0) != 0);
      if (nice_icb_cmd_valid && nice_icb_cmd_ready)
      begin
        widx = nice_icb_cmd.addr[7:2];
        if (!nice_icb_cmd.read)
        begin
          mem[widx] = nice_icb_cmd.wdata;
        end
        lat     = int'($urandom_range(MAX_LAT, 0));
        ent.due = mem_cyc + 1 + lat;
        // Keep command order
        if (ent.due <= last_due)
        begin
          ent.due = last_due + 1;
        end
        last_due       = ent.due;
        ent.rsp.rdata  = nice_icb_cmd.read ? mem[widx] : '0;
        ent.rsp.err    = nice_icb_cmd.read && (widx == ERR_WORD);
        rsp_q.push_back(ent);
      end
    end
  end

  always @(posedge nice_clk)
  begin
    timeout_cnt <= timeout_cnt + 1;
    if (timeout_cnt >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////
  initial
  begin : stimulus
    int i;
    nice_rst_n     = 1'b0;
    nice_req_valid = 1'b0;
    nice_req_inst  = '0;
    nice_req_rs1   = '0;
    nice_rsp_ready = 1'b0;
    for (i = 0; i < MEM_WORDS; i++)
    begin
      mem_exp[i] = fill_word(i);
    end
    for (i = 0; i < ROW_WORDS; i++)
    begin
      row_exp[i] = '0;
    end
    stim_table[0] = '{encode_rtype(F7_LBUF, F3_BUF), 32'h20, 4'd0, OP_LBUF};
    stim_table[1] = '{encode_rtype(F7_SBUF, F3_BUF), 32'h80, 4'd2, OP_SBUF};
    stim_table[2] = '{encode_rtype(F7_ROWSUM, F3_ROWSUM), 32'h40, 4'd0, OP_ROWSUM};
    stim_table[3] = '{encode_rtype(F7_SBUF, F3_BUF), 32'hb0, 4'd1, OP_SBUF};
    stim_table[4] = '{32'h0000_0033, 32'h0, 4'd5, OP_ILLEGAL};
    // Covers the error word
    stim_table[5] = '{encode_rtype(F7_ROWSUM, F3_ROWSUM), 32'hc4, 4'd4, OP_ROWSUM};
    stim_table[6] = '{encode_rtype(F7_LBUF, F3_BUF), 32'hc0, 4'd0, OP_LBUF};
    stim_table[7] = '{encode_rtype(F7_SBUF, F3_BUF), 32'h10, 4'd3, OP_SBUF};
    stim_table[8] = '{encode_rtype(F7_ROWSUM, F3_ROWSUM), 32'he0, 4'd2, OP_ROWSUM};
    // Custom-3 with a func3/func7 mix that is not defined
    stim_table[9] = '{encode_rtype(F7_LBUF, F3_ROWSUM), 32'h20, 4'd2, OP_ILLEGAL};
    repeat (10)
    begin
      @(negedge nice_clk);
    end
    nice_rst_n = 1'b1;
    @(negedge nice_clk);
    // Quiet outputs after reset
    check_value("nice_rsp_valid", 32'(nice_rsp_valid), 32'd0);
    check_value("nice_icb_cmd_valid", 32'(nice_icb_cmd_valid), 32'd0);
    check_value("nice_active", 32'(nice_active), 32'd0);
    check_value("nice_mem_holdup", 32'(nice_mem_holdup), 32'd0);
    check_value("nice_req_ready", 32'(nice_req_ready), 32'd1);
    for (i = 0; i < NUM_ROWS; i++)
    begin
      run_row(stim_table[i]);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire

/* nice_core_properties.sv */
// Protocol assertions for nice_core, attached to every nice_core instance through bind
`timescale 1ns/1ps
`default_nettype none

module nice_core_properties
  import nice_pkg::*;
(
  input logic      nice_clk,
  input logic      nice_rst_n,
  input logic      nice_req_ready,
  input logic      nice_rsp_valid,
  input logic      nice_rsp_ready,
  input nice_rsp_t nice_rsp,
  input logic      nice_icb_cmd_valid,
  input logic      nice_icb_cmd_ready,
  input icb_cmd_t  nice_icb_cmd,
  input logic      nice_mem_holdup
);

  // Response held until the CPU takes it
  rsp_stable: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_rsp_valid && !nice_rsp_ready |=> nice_rsp_valid && $stable(nice_rsp))
    else $error("response dropped or changed before it was taken");

  // Command held until taken; write data only counts for writes
  cmd_stable: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_icb_cmd_valid && !nice_icb_cmd_ready |=> nice_icb_cmd_valid
      && $stable(nice_icb_cmd.addr) && $stable(nice_icb_cmd.read)
      && (nice_icb_cmd.read || $stable(nice_icb_cmd.wdata)))
    else $error("memory command dropped or changed before it was taken");

  // Ready only in idle, and idle issues nothing
  idle_no_cmd: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_req_ready |-> !nice_icb_cmd_valid)
    else $error("memory command valid while idle");

  busy_blocks_req: assert property (@(posedge nice_clk) disable iff (!nice_rst_n)
    nice_mem_holdup || nice_rsp_valid |-> !nice_req_ready)
    else $error("request ready while an operation is in progress");

endmodule

bind nice_core nice_core_properties nice_core_properties_i (
  .nice_clk(nice_clk), .nice_rst_n(nice_rst_n), .nice_req_ready(nice_req_ready),
  .nice_rsp_valid(nice_rsp_valid), .nice_rsp_ready(nice_rsp_ready), .nice_rsp(nice_rsp),
  .nice_icb_cmd_valid(nice_icb_cmd_valid), .nice_icb_cmd_ready(nice_icb_cmd_ready),
  .nice_icb_cmd(nice_icb_cmd), .nice_mem_holdup(nice_mem_holdup)
);

`default_nettype wire

/* nice_core.sv */
// Top level of the NICE coprocessor, connects decode, execute, row buffer and result blocks
`timescale 1ns/1ps
`default_nettype none

module nice_core
  import nice_pkg::*;
#(
  parameter int ROW_WORDS = 3
) (
  input  logic      nice_clk,
  input  logic      nice_rst_n,
  input  logic      nice_req_valid,
  output logic      nice_req_ready,
  input  xlen_t     nice_req_inst,
  input  addr_t     nice_req_rs1,
  output logic      nice_rsp_valid,
  input  logic      nice_rsp_ready,
  output nice_rsp_t nice_rsp,
  output logic      nice_icb_cmd_valid,
  input  logic      nice_icb_cmd_ready,
  output icb_cmd_t  nice_icb_cmd,
  input  logic      nice_icb_rsp_valid,
  input  icb_rsp_t  nice_icb_rsp,
  output logic      nice_active,
  output logic      nice_mem_holdup
);

  nice_op_e op;
  addr_t    cmd_addr;
  logic     cmd_read;
  row_idx_t row_rd_idx;
  xlen_t    row_rd_data;
  logic     row_ld;
  row_idx_t row_ld_idx;
  logic     row_acc;
  row_idx_t row_acc_idx;
  xlen_t    row_acc_data;
  logic     op_start;
  logic     sum_rsp;
  row_idx_t sum_rsp_idx;
  logic     sum_drained;
  logic     rsp_taken;

  assign rsp_taken = nice_rsp_valid & nice_rsp_ready;

  // Write data is only meaningful when read is low, i.e. for sbuf
  assign nice_icb_cmd = '{addr: cmd_addr, read: cmd_read, wdata: row_rd_data};

  ////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////
  nice_decode nice_decode_i (.inst(nice_req_inst), .op(op));

  nice_exec #(.ROW_WORDS(ROW_WORDS)) nice_exec_i (
    .nice_clk(nice_clk), .nice_rst_n(nice_rst_n),
    .req_valid(nice_req_valid), .req_ready(nice_req_ready), .op(op), .rs1(nice_req_rs1),
    .icb_cmd_valid(nice_icb_cmd_valid), .icb_cmd_ready(nice_icb_cmd_ready),
    .icb_cmd_addr(cmd_addr), .icb_cmd_read(cmd_read), .icb_rsp_valid(nice_icb_rsp_valid),
    .row_rd_idx(row_rd_idx), .row_ld(row_ld), .row_ld_idx(row_ld_idx),
    .op_start(op_start), .sum_rsp(sum_rsp), .sum_rsp_idx(sum_rsp_idx),
    .sum_drained(sum_drained), .rsp_valid(nice_rsp_valid), .rsp_ready(nice_rsp_ready),
    .active(nice_active), .mem_holdup(nice_mem_holdup)
  );

  nice_row_buf #(.ROW_WORDS(ROW_WORDS)) nice_row_buf_i (
    .nice_clk(nice_clk), .nice_rst_n(nice_rst_n),
    .ld(row_ld), .ld_idx(row_ld_idx), .ld_data(nice_icb_rsp.rdata),
    .acc(row_acc), .acc_idx(row_acc_idx), .acc_data(row_acc_data),
    .rd_idx(row_rd_idx), .rd_data(row_rd_data)
  );

  nice_result nice_result_i (
    .nice_clk(nice_clk), .nice_rst_n(nice_rst_n), .op_start(op_start),
    .icb_rsp_valid(nice_icb_rsp_valid), .icb_rsp(nice_icb_rsp),
    .sum_rsp(sum_rsp), .sum_rsp_idx(sum_rsp_idx), .rsp_taken(rsp_taken),
    .row_acc(row_acc), .row_acc_idx(row_acc_idx), .row_acc_data(row_acc_data),
    .sum_drained(sum_drained), .rsp(nice_rsp)
  );

endmodule

`default_nettype wire

/* nice_result.sv */
// Result path: rowsum word stage, running sum, sticky memory error and the CPU response value
`timescale 1ns/1ps
`default_nettype none

module nice_result
  import nice_pkg::*;
(
  input  logic      nice_clk,
  input  logic      nice_rst_n,
  input  logic      op_start,
  input  logic      icb_rsp_valid,
  input  icb_rsp_t  icb_rsp,
  input  logic      sum_rsp,
  input  row_idx_t  sum_rsp_idx,
  input  logic      rsp_taken,
  output logic      row_acc,
  output row_idx_t  row_acc_idx,
  output xlen_t     row_acc_data,
  output logic      sum_drained,
  output nice_rsp_t rsp
);

  logic     stg_valid_q;
  row_idx_t stg_idx_q;
  xlen_t    stg_data_q;
  xlen_t    sum_q;
  // High from op_start while no memory error seen
  logic     ok_q;

  ////////////////////////////////////////////////////////////
  // Response-data stage, one word deep
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      stg_valid_q <= 1'b0;
    end
    else
    begin
      stg_valid_q <= sum_rsp;
    end
  end

  always_ff @(posedge nice_clk)
  begin
    if (sum_rsp)
    begin
      stg_idx_q  <= sum_rsp_idx;
      stg_data_q <= icb_rsp.rdata;
    end
  end

  // Stage always empties in one cycle, so only a new word keeps it busy
  assign sum_drained = ~sum_rsp;

  // Same staged word goes into the row buffer entry
  assign row_acc      = stg_valid_q;
  assign row_acc_idx  = stg_idx_q;
  assign row_acc_data = stg_data_q;

  ////////////////////////////////////////////////////////////
  // Running sum and sticky error
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      sum_q <= '0;
      ok_q  <= 1'b0;
    end
    else
    begin
      // Sum reads zero between operations
      if (rsp_taken)
      begin
        sum_q <= '0;
      end
      else if (stg_valid_q)
      begin
        sum_q <= (stg_idx_q == '0) ? stg_data_q : sum_q + stg_data_q;
      end
      if (op_start)
      begin
        ok_q <= 1'b1;
      end
      else if (rsp_taken || (icb_rsp_valid && icb_rsp.err))
      begin
        ok_q <= 1'b0;
      end
    end
  end

  // An illegal op never sets ok, so it reports err with zero data
  assign rsp.rdat = sum_q;
  assign rsp.err  = ~ok_q;

endmodule

`default_nettype wire

/* nice_row_buf.sv */
// Row buffer storage, written by lbuf, accumulated by rowsum and read out for sbuf
`timescale 1ns/1ps
`default_nettype none

module nice_row_buf
  import nice_pkg::*;
#(
  parameter int ROW_WORDS = 3
) (
  input  logic     nice_clk,
  input  logic     nice_rst_n,
  input  logic     ld,
  input  row_idx_t ld_idx,
  input  xlen_t    ld_data,
  input  logic     acc,
  input  row_idx_t acc_idx,
  input  xlen_t    acc_data,
  input  row_idx_t rd_idx,
  output xlen_t    rd_data
);

  xlen_t row_q [ROW_WORDS];

  // Load wins over accumulate; the FSM never asks for both
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      for (int i = 0; i < ROW_WORDS; i++)
      begin
        row_q[i] <= '0;
      end
    end
    else if (ld)
    begin
      row_q[ld_idx] <= ld_data;
    end
    else if (acc)
    begin
      row_q[acc_idx] <= row_q[acc_idx] + acc_data;
    end
  end

  // Past the last entry the index points nowhere, read zero
  assign rd_data = (int'(rd_idx) < ROW_WORDS) ? row_q[rd_idx] : '0;

endmodule

`default_nettype wire

/* nice_exec.sv */
// Control FSM for the coprocessor, issues memory commands and tracks responses per operation
`timescale 1ns/1ps
`default_nettype none

module nice_exec
  import nice_pkg::*;
#(
  parameter int ROW_WORDS = 3
) (
  input  logic     nice_clk,
  input  logic     nice_rst_n,
  input  logic     req_valid,
  output logic     req_ready,
  input  nice_op_e op,
  input  addr_t    rs1,
  output logic     icb_cmd_valid,
  input  logic     icb_cmd_ready,
  output addr_t    icb_cmd_addr,
  output logic     icb_cmd_read,
  input  logic     icb_rsp_valid,
  output row_idx_t row_rd_idx,
  output logic     row_ld,
  output row_idx_t row_ld_idx,
  output logic     op_start,
  output logic     sum_rsp,
  output row_idx_t sum_rsp_idx,
  input  logic     sum_drained,
  output logic     rsp_valid,
  input  logic     rsp_ready,
  output logic     active,
  output logic     mem_holdup
);

  // Counters run one past the last word, so they need a spare bit
  typedef logic [2:0] cnt_t;

  localparam cnt_t CNT_NUM  = cnt_t'(ROW_WORDS);
  localparam cnt_t CNT_LAST = cnt_t'(ROW_WORDS - 1);

  nice_state_e state_q;
  cnt_t        cmd_cnt_q;
  cnt_t        rsp_cnt_q;
  addr_t       addr_q;

  logic req_hs;
  logic cmd_hs;
  logic mem_state;
  logic rsp_in;
  logic rsp_last;
  logic rsp_all;

  ////////////////////////////////////////////////////////////
  // Handshakes and counter status
  ////////////////////////////////////////////////////////////
  assign req_hs    = req_valid & req_ready;
  assign cmd_hs    = icb_cmd_valid & icb_cmd_ready;
  assign mem_state = state_q inside {ST_LBUF, ST_SBUF, ST_ROWSUM};
  // Memory responses only arrive during a memory state
  assign rsp_in    = mem_state & icb_rsp_valid;
  assign rsp_last  = rsp_in & (rsp_cnt_q == CNT_LAST);
  assign rsp_all   = (rsp_cnt_q == CNT_NUM);

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      state_q <= ST_IDLE;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (req_hs)
          begin
            case (op)
              OP_LBUF:   state_q <= ST_LBUF;
              OP_SBUF:   state_q <= ST_SBUF;
              OP_ROWSUM: state_q <= ST_ROWSUM;
              // Illegal goes straight to the response
              default:   state_q <= ST_RESP;
            endcase
          end
        end
        ST_LBUF, ST_SBUF:
        begin
          if (rsp_last)
          begin
            state_q <= ST_RESP;
          end
        end
        // Wait until the last word has passed the result stage
        ST_ROWSUM:
        begin
          if (rsp_all && sum_drained)
          begin
            state_q <= ST_RESP;
          end
        end
        ST_RESP:
        begin
          if (rsp_ready)
          begin
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////
  // Command and response counters, address generation
  ////////////////////////////////////////////////////////////
  always_ff @(posedge nice_clk or negedge nice_rst_n)
  begin
    if (!nice_rst_n)
    begin
      cmd_cnt_q <= '0;
      rsp_cnt_q <= '0;
      addr_q    <= '0;
    end
    else if (req_hs)
    begin
      cmd_cnt_q <= '0;
      rsp_cnt_q <= '0;
      addr_q    <= rs1;
    end
    else
    begin
      if (cmd_hs)
      begin
        cmd_cnt_q <= cmd_cnt_q + cnt_t'(1);
        addr_q    <= addr_q + WORD_BYTES;
      end
      if (rsp_in && !rsp_all)
      begin
        rsp_cnt_q <= rsp_cnt_q + cnt_t'(1);
      end
    end
  end

  // Commands go out back to back until every word is issued
  assign icb_cmd_valid = mem_state & (cmd_cnt_q < CNT_NUM);
  assign icb_cmd_addr  = addr_q;
  assign icb_cmd_read  = (state_q != ST_SBUF);

  // Store data follows the command count, loads follow the response count
  assign row_rd_idx  = row_idx_t'(cmd_cnt_q);
  assign row_ld      = (state_q == ST_LBUF) & icb_rsp_valid;
  assign row_ld_idx  = row_idx_t'(rsp_cnt_q);
  assign sum_rsp     = (state_q == ST_ROWSUM) & icb_rsp_valid;
  assign sum_rsp_idx = row_idx_t'(rsp_cnt_q);

  // Only memory operations arm the result error tracking
  assign op_start = req_hs & (op != OP_ILLEGAL);

  // Status towards the CPU
  assign req_ready  = (state_q == ST_IDLE);
  assign rsp_valid  = (state_q == ST_RESP);
  assign active     = (state_q != ST_IDLE) | req_valid;
  assign mem_holdup = mem_state;

endmodule

`default_nettype wire

/* nice_decode.sv */
// Instruction decoder, maps a custom-3 request instruction onto the coprocessor operation
`timescale 1ns/1ps
`default_nettype none

module nice_decode
  import nice_pkg::*;
(
  input  xlen_t    inst,
  output nice_op_e op
);

  // R-type fields
  logic [6:0] opcode;
  logic [2:0] func3;
  logic [6:0] func7;

  assign opcode = inst[6:0];
  assign func3  = inst[14:12];
  assign func7  = inst[31:25];

  // Anything outside the three encodings is illegal
  always_comb
  begin
    op = OP_ILLEGAL;
    if (opcode == OPC_CUSTOM3)
    begin
      if (func3 == F3_BUF && func7 == F7_LBUF)
      begin
        op = OP_LBUF;
      end
      else if (func3 == F3_BUF && func7 == F7_SBUF)
      begin
        op = OP_SBUF;
      end
      else if (func3 == F3_ROWSUM && func7 == F7_ROWSUM)
      begin
        op = OP_ROWSUM;
      end
    end
  end

endmodule

`default_nettype wire

/* nice_pkg.sv */
// Shared widths, instruction encodings, state enums and bus structs for the NICE coprocessor
`default_nettype none

package nice_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////
  localparam int XLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN-1:0] addr_t;
  // Row buffer index, room for 4 entries
  typedef logic [1:0]      row_idx_t;

  // Byte step between consecutive words
  localparam addr_t WORD_BYTES = 32'd4;

  ////////////////////////////////////////////////////////////
  // Custom-3 R-type encodings
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_CUSTOM3 = 7'b1111011;
  localparam logic [2:0] F3_BUF      = 3'b010;
  localparam logic [2:0] F3_ROWSUM   = 3'b110;
  localparam logic [6:0] F7_LBUF     = 7'b0000001;
  localparam logic [6:0] F7_SBUF     = 7'b0000010;
  localparam logic [6:0] F7_ROWSUM   = 7'b0000110;

  typedef enum logic [1:0] {OP_LBUF, OP_SBUF, OP_ROWSUM, OP_ILLEGAL} nice_op_e;

  typedef enum logic [2:0] {ST_IDLE, ST_LBUF, ST_SBUF, ST_ROWSUM, ST_RESP} nice_state_e;

  ////////////////////////////////////////////////////////////
  // Bus payloads
  ////////////////////////////////////////////////////////////
  // Memory command, one word per beat
  typedef struct packed {addr_t addr; logic read; xlen_t wdata;} icb_cmd_t;

  typedef struct packed {xlen_t rdata; logic err;} icb_rsp_t;

  // Result back to the CPU
  typedef struct packed {xlen_t rdat; logic err;} nice_rsp_t;

endpackage

`default_nettype wire
